/* verilog/colmix_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width and address map constants of the colour mixer
// pixel words are prio over col, the low 4 col bits are the index
// index 15 marks a transparent pixel on either layer
// host addresses with bit 12 set go to the palette space
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef COLMIX_CONSTS_SVH
`define COLMIX_CONSTS_SVH

// full pixel word, also the palette address width
`define PXL_W 12

// colour part of a pixel, palette bank plus index
`define COL_W 9

// layer priority field on top of the colour
`define PRIO_W 3

// colour index that leaves the pixel transparent
`define BLANK_IDX 15

// host bus widths
`define HOST_AW 13
`define HOST_DW 16

// set means palette entry, clear means register space
`define PAL_SEL_BIT 12

// the only register in the register space
`define CTRL_ADDR 0

`endif

/* verilog/colmix_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// struct types shared by the colour mixer blocks
// field widths come from colmix_consts.svh
// reserved control bits are stored but never decoded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "colmix_consts.svh"

package colmix_pkg;

    // one layer pixel as it leaves the tile or sprite engine
    typedef struct packed {
        logic [`PRIO_W-1:0] prio;
        // low 4 bits are the colour index
        logic [`COL_W-1:0]  col;
    } pxl_t;

    // layer control register as the host writes it
    typedef struct packed {
        logic [1:0]  rsv_hi;
        // zero forces objects above every scroll layer
        logic [1:0]  obj_top_n;
        logic [10:0] rsv_mid;
        // objects visible
        logic        obj_en;
    } layer_ctrl_t;

    // host write, held stable while req is high
    typedef struct packed {
        logic [`HOST_AW-1:0] addr;
        logic [`HOST_DW-1:0] data;
    } host_wr_t;

    // palette write, we lasts one clock
    typedef struct packed {
        logic                we;
        logic [`PXL_W-1:0]   addr;
        logic [`HOST_DW-1:0] data;
    } pal_wr_t;

    // palette word, brightness on top of 4-bit channels
    typedef struct packed {
        logic [3:0] br;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pal_entry_t;

    // scaled colour going out to the video DAC
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

/* verilog/layer_ctrl_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host write port, four-phase req/ack slave
// the write lands on the edge that raises ack
// wr must stay stable while req is high
// writes outside the map are acked and dropped
// no host reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "colmix_consts.svh"

module layer_ctrl_regs (
    input  logic                     clk,
    input  logic                     rst_n,

    // host handshake
    input  logic                     req,
    output logic                     ack,
    input  colmix_pkg::host_wr_t     wr,

    // decoded outputs
    output colmix_pkg::layer_ctrl_t  ctrl,
    output colmix_pkg::pal_wr_t      pal_wr
);

    import colmix_pkg::*;

    // slave side of the handshake
    typedef enum logic {
        ST_IDLE,
        ST_ACKED
    } hs_state_t;

    hs_state_t   state;
    logic        accept;
    logic        pal_hit;
    logic        ctrl_hit;
    layer_ctrl_t ctrl_q;

    // a new write only counts while ack is low
    assign accept = req && (state == ST_IDLE);

    // palette space wins over the register map
    assign pal_hit  = wr.addr[`PAL_SEL_BIT];
    assign ctrl_hit = !pal_hit && (wr.addr == `HOST_AW'(`CTRL_ADDR));

    // ack follows the state, so it rises on the accepting edge
    assign ack = (state == ST_ACKED);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ACKED;
                    end
                end
                // hold ack until the host lets req go
                ST_ACKED: begin
                    if (!req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // layer control, loaded on the accepting edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (accept && ctrl_hit) begin
            ctrl_q <= layer_ctrl_t'(wr.data);
        end
    end

    assign ctrl = ctrl_q;

    // palette write strobe is live only in the accepting cycle
    // the ram samples it on that same edge
    always_comb begin
        pal_wr.we   = accept && pal_hit;
        pal_wr.addr = wr.addr[`PXL_W-1:0];
        pal_wr.data = wr.data;
    end

endmodule

/* verilog/prio_mixer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks scroll or object pixel per pixel clock
// one register stage, advances only with pxl_cen
// an object pixel leaves with its prio cleared
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "colmix_consts.svh"

module prio_mixer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxl_cen,

    input  colmix_pkg::layer_ctrl_t  ctrl,

    input  colmix_pkg::pxl_t         scr_pxl,
    input  colmix_pkg::pxl_t         obj_pxl,
    output colmix_pkg::pxl_t         pxl
);

    import colmix_pkg::*;

    logic scr_blank;
    logic obj_blank;
    logic obj_top;
    logic obj_first;
    logic use_scr;
    pxl_t obj_out;
    pxl_t nxt_pxl;

    // transparent when the colour index hits the blank code
    assign scr_blank = (scr_pxl.col[3:0] == 4'(`BLANK_IDX));
    assign obj_blank = (obj_pxl.col[3:0] == 4'(`BLANK_IDX));

    // zero in obj_top_n puts objects over everything
    assign obj_top = (ctrl.obj_top_n == 2'b00);

    always_comb begin
        // low two prio bits rank the object against the scroll layer
        case (obj_pxl.prio[1:0])
            2'b10,
            2'b11:   obj_first = 1'b1;
            // only scroll layer 1 sits above these
            default: obj_first = (scr_pxl.prio != 3'd1);
        endcase
        if (obj_top) begin
            obj_first = 1'b1;
        end

        // the losing layer shows through a blank winner
        if (obj_first) begin
            use_scr = obj_blank;
        end else begin
            use_scr = !scr_blank;
        end
    end

    // object colour only, priority is not passed on
    always_comb begin
        obj_out      = obj_pxl;
        obj_out.prio = '0;
    end

    // objects switched off means scroll only
    assign nxt_pxl = (!ctrl.obj_en || use_scr) ? scr_pxl : obj_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= nxt_pxl;
        end
    end

endmodule

/* verilog/palette_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4096 entry palette, addressed by the whole pixel word
// entries come up undefined, write before use
// lookup is registered on pxl_cen
// read during write returns the old entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "colmix_consts.svh"

module palette_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl_cen,

    input  colmix_pkg::pal_wr_t  pal_wr,

    input  colmix_pkg::pxl_t     pxl,
    output colmix_pkg::rgb_t     rgb
);

    import colmix_pkg::*;

    pal_entry_t pal_mem [0:(1 << `PXL_W)-1];
    pal_entry_t rd_ent;

    // channel times (br+1), at most 15 * 16 = 240
    function automatic logic [7:0] scale_chan(input logic [3:0] chan,
                                              input logic [3:0] br);
        logic [4:0] gain;
        gain       = {1'b0, br} + 5'd1;
        scale_chan = {4'b0, chan} * {3'b0, gain};
    endfunction

    // host side write port
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_mem[pal_wr.addr] <= pal_entry_t'(pal_wr.data);
        end
    end

    // pixel side read, sampled by the output register below
    // a write on the same edge lands after the sample
    assign rd_ent = pal_mem[pxl];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb.r <= scale_chan(rd_ent.r, rd_ent.br);
            rgb.g <= scale_chan(rd_ent.g, rd_ent.br);
            rgb.b <= scale_chan(rd_ent.b, rd_ent.br);
        end
    end

endmodule

/* verilog/colmix_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// final colour stage of the video chip
// rgb follows the layer pixels two pxl_cen edges later
// no back-pressure on the pixel path
// the host is paced only by req/ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module colmix_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,

    // host write port
    input  logic                  req,
    output logic                  ack,
    input  colmix_pkg::host_wr_t  wr,

    // layer pixels from the fetch engines
    input  colmix_pkg::pxl_t      scr_pxl,
    input  colmix_pkg::pxl_t      obj_pxl,

    // scaled colour out
    output colmix_pkg::rgb_t      rgb
);

    import colmix_pkg::*;

    // decoder to mixer
    layer_ctrl_t ctrl;
    // decoder to palette
    pal_wr_t     pal_wr;
    // mixer to palette
    pxl_t        mix_pxl;

    // host writes into control and palette
    layer_ctrl_regs layer_ctrl_regs_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .ack    (ack),
        .wr     (wr),
        .ctrl   (ctrl),
        .pal_wr (pal_wr)
    );

    // first pixel stage, layer priority
    prio_mixer prio_mixer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .ctrl    (ctrl),
        .scr_pxl (scr_pxl),
        .obj_pxl (obj_pxl),
        .pxl     (mix_pxl)
    );

    // second pixel stage, colour lookup and brightness
    palette_ram palette_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .pal_wr  (pal_wr),
        .pxl     (mix_pxl),
        .rgb     (rgb)
    );

endmodule

/* dv/colmix_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for colmix_top
// table cases cover priority, obj_en and obj_top_n
// random pixels only use palette entries with col[8:4] zero
// palette words follow a pattern of address and seed
// stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "colmix_consts.svh"

module colmix_tb;

    import colmix_pkg::*;

    localparam int          TBL_N       = 72;
    localparam int          RAND_N      = 200;
    localparam int          CYCLE_LIMIT = (TBL_N + RAND_N) * 8 + 200;
    localparam logic [15:0] RAND_SEED   = 16'hc3a5;

    // one pixel case with its expected colour
    typedef struct packed {
        layer_ctrl_t ctrl;
        pxl_t        scr;
        pxl_t        obj;
        logic [15:0] seed;
        rgb_t        exp;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pxl_cen;
    logic        req;
    logic        ack;
    host_wr_t    wr;
    pxl_t        scr_pxl;
    pxl_t        obj_pxl;
    rgb_t        rgb;

    row_t        tbl [0:TBL_N-1];
    int          tbl_len;
    layer_ctrl_t cur_ctrl;
    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    rgb_t        exp_q [$];
    rgb_t        last_exp;

    colmix_top colmix_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .req     (req),
        .ack     (ack),
        .wr      (wr),
        .scr_pxl (scr_pxl),
        .obj_pxl (obj_pxl),
        .rgb     (rgb)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // watchdog sized from the number of cases
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation hung");
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first error");
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        rand_bits = v;
    endfunction

    // random prio and index, bank bits kept at zero
    task automatic random_pixel(output pxl_t p);
        logic [31:0] pr;
        logic [31:0] ix;
        pr = rand_bits(3);
        ix = rand_bits(4);
        p  = pxl_t'({pr[2:0], 5'b00000, ix[3:0]});
    endtask

    // odd multiplier, so every address bit reaches the word
    function automatic logic [15:0] pal_pattern(input logic [11:0] addr,
                                                input logic [15:0] seed);
        pal_pattern = ({4'b0000, addr} * 16'h9e37) ^ seed;
    endfunction

    function automatic logic [7:0] brightness(input logic [3:0] ch, input logic [3:0] br);
        brightness = 8'(int'(ch) * (int'(br) + 1));
    endfunction

    // layer selection as the mixer should do it
    function automatic pxl_t pick_pixel(input layer_ctrl_t c, input pxl_t s, input pxl_t o);
        logic s_blank;
        logic o_blank;
        logic obj_rank;
        pxl_t o_out;
        s_blank    = (s.col[3:0] == 4'(`BLANK_IDX));
        o_blank    = (o.col[3:0] == 4'(`BLANK_IDX));
        obj_rank   = (c.obj_top_n == 2'b00)
                  || (o.prio[1:0] == 2'b10) || (o.prio[1:0] == 2'b11)
                  || ((o.prio[1:0] <= 2'b01) && (s.prio != 3'd1));
        o_out      = o;
        o_out.prio = '0;
        if (!c.obj_en) begin
            pick_pixel = s;
        end else if (obj_rank) begin
            pick_pixel = o_blank ? s : o_out;
        end else begin
            pick_pixel = s_blank ? o_out : s;
        end
    endfunction

    function automatic rgb_t expect_rgb(input pxl_t sel, input logic [15:0] seed);
        pal_entry_t e;
        e            = pal_entry_t'(pal_pattern(sel, seed));
        expect_rgb.r = brightness(e.r, e.br);
        expect_rgb.g = brightness(e.g, e.br);
        expect_rgb.b = brightness(e.b, e.br);
    endfunction

    // full four-phase write, ack one cycle after req
    task automatic host_write(input logic [`HOST_AW-1:0] waddr,
                              input logic [`HOST_DW-1:0] wdata);
        @(posedge clk);
        req     <= 1'b1;
        wr.addr <= waddr;
        wr.data <= wdata;
        @(negedge clk);
        check_val("ack", 32'(ack), 32'd0);
        @(negedge clk);
        check_val("ack", 32'(ack), 32'd1);
        @(posedge clk);
        req <= 1'b0;
        // ack stays up until req is seen low
        @(negedge clk);
        check_val("ack", 32'(ack), 32'd1);
        while (ack) begin
            @(negedge clk);
        end
    endtask

    task automatic add_row(input layer_ctrl_t c, input pxl_t s, input pxl_t o,
                           input logic [15:0] seed);
        if (tbl_len < TBL_N) begin
            tbl[tbl_len].ctrl = c;
            tbl[tbl_len].scr  = s;
            tbl[tbl_len].obj  = o;
            tbl[tbl_len].seed = seed;
            tbl[tbl_len].exp  = expect_rgb(pick_pixel(c, s, o), seed);
        end
        tbl_len++;
    endtask

    task automatic build_table();
        int         k;
        logic [2:0] s_prio;
        logic [3:0] s_idx;
        logic [3:0] o_idx;
        // every object prio against scroll prio 1 and 3, blank on either side
        for (int op = 0; op < 8; op++) begin
            for (int sp = 0; sp < 2; sp++) begin
                for (int bk = 0; bk < 4; bk++) begin
                    k      = op * 8 + sp * 4 + bk;
                    s_prio = (sp == 0) ? 3'd1 : 3'd3;
                    s_idx  = bk[0] ? 4'(`BLANK_IDX) : 4'(k % 15);
                    o_idx  = bk[1] ? 4'(`BLANK_IDX) : 4'((k + 7) % 15);
                    add_row(layer_ctrl_t'(16'h3001),
                            pxl_t'({s_prio, 5'(k), s_idx}),
                            pxl_t'({3'(op), 5'(k + 9), o_idx}),
                            16'(k * 3869 + 11329));
                end
            end
        end
        // objects switched off, scroll always shows
        add_row(layer_ctrl_t'(16'h1000), pxl_t'({3'd1, 9'h021}), pxl_t'({3'd3, 9'h042}), 16'h1111);
        add_row(layer_ctrl_t'(16'h1000), pxl_t'({3'd3, 9'h033}), pxl_t'({3'd0, 9'h05f}), 16'h2222);
        add_row(layer_ctrl_t'(16'h1000), pxl_t'({3'd1, 9'h02f}), pxl_t'({3'd2, 9'h047}), 16'h3333);
        add_row(layer_ctrl_t'(16'h1000), pxl_t'({3'd5, 9'h1a6}), pxl_t'({3'd7, 9'h0c9}), 16'h4444);
        // objects forced on top
        add_row(layer_ctrl_t'(16'h0001), pxl_t'({3'd1, 9'h034}), pxl_t'({3'd0, 9'h068}), 16'h5555);
        add_row(layer_ctrl_t'(16'h0001), pxl_t'({3'd1, 9'h035}), pxl_t'({3'd1, 9'h06f}), 16'h6666);
        add_row(layer_ctrl_t'(16'h0001), pxl_t'({3'd3, 9'h03f}), pxl_t'({3'd5, 9'h0d2}), 16'h7777);
        add_row(layer_ctrl_t'(16'h0001), pxl_t'({3'd1, 9'h13a}), pxl_t'({3'd4, 9'h0e1}), 16'h8888);
    endtask

    task automatic apply_row(input int n);
        logic [11:0] o_addr;
        o_addr = {3'b000, tbl[n].obj.col};
        if (tbl[n].ctrl != cur_ctrl) begin
            host_write(`HOST_AW'(`CTRL_ADDR), tbl[n].ctrl);
            cur_ctrl = tbl[n].ctrl;
        end
        // both candidate entries, a chosen object pixel has prio zero
        host_write({1'b1, tbl[n].scr}, pal_pattern(tbl[n].scr, tbl[n].seed));
        host_write({1'b1, o_addr}, pal_pattern(o_addr, tbl[n].seed));
        @(posedge clk);
        scr_pxl <= tbl[n].scr;
        obj_pxl <= tbl[n].obj;
        // mixer edge then palette edge
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        check_val("rgb", {8'h00, rgb}, {8'h00, tbl[n].exp});
    endtask

    initial begin
        pxl_t        s;
        pxl_t        o;
        pxl_t        held;
        logic [11:0] a12;
        rst_n    = 1'b0;
        pxl_cen  = 1'b1;
        req      = 1'b0;
        wr       = '0;
        scr_pxl  = '0;
        obj_pxl  = '0;
        tbl_len  = 0;
        cur_ctrl = '0;
        lfsr     = 32'h230b1cb8;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("ack", 32'(ack), 32'd0);
        check_val("rgb", {8'h00, rgb}, 32'd0);

        build_table();
        if (tbl_len != TBL_N) begin
            $display("case table holds %0d rows instead of %0d", tbl_len, TBL_N);
            $display("*** TEST FAILED ***");
            $fatal(1, "bad case table");
        end
        for (int n = 0; n < TBL_N; n++) begin
            apply_row(n);
        end

        // random pass, objects on, normal ranking
        host_write(`HOST_AW'(`CTRL_ADDR), 16'h1001);
        cur_ctrl = layer_ctrl_t'(16'h1001);
        for (int a = 0; a < 128; a++) begin
            a12 = {3'(a >> 4), 5'b00000, 4'(a)};
            host_write({1'b1, a12}, pal_pattern(a12, RAND_SEED));
        end
        // one pixel per clock, result two edges behind
        for (int i = 0; i < RAND_N + 2; i++) begin
            @(posedge clk);
            if (i < RAND_N) begin
                random_pixel(s);
                random_pixel(o);
                scr_pxl <= s;
                obj_pxl <= o;
                exp_q.push_back(expect_rgb(pick_pixel(cur_ctrl, s, o), RAND_SEED));
            end
            @(negedge clk);
            if (i >= 2) begin
                last_exp = exp_q.pop_front();
                check_val("rgb", {8'h00, rgb}, {8'h00, last_exp});
            end
        end

        // freeze the pixel path while the inputs keep moving
        held = pick_pixel(cur_ctrl, s, o);
        @(posedge clk);
        pxl_cen <= 1'b0;
        for (int h = 0; h < 6; h++) begin
            random_pixel(s);
            random_pixel(o);
            scr_pxl <= s;
            obj_pxl <= o;
            @(negedge clk);
            check_val("rgb", {8'h00, rgb}, {8'h00, last_exp});
            @(posedge clk);
        end
        // a new palette word under the held pixel stays out of rgb
        host_write({1'b1, held}, pal_pattern(held, ~RAND_SEED));
        check_val("rgb", {8'h00, rgb}, {8'h00, last_exp});
        // resume, the held pixel is looked up first, with the new word
        @(posedge clk);
        pxl_cen <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_val("rgb", {8'h00, rgb}, {8'h00, expect_rgb(held, ~RAND_SEED)});
        // then the last inputs flow through
        @(posedge clk);
        @(negedge clk);
        last_exp = expect_rgb(pick_pixel(cur_ctrl, s, o), RAND_SEED);
        check_val("rgb", {8'h00, rgb}, {8'h00, last_exp});

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/colmix_pkg.sv
verilog/layer_ctrl_regs.sv
verilog/prio_mixer.sv
verilog/palette_ram.sv
verilog/colmix_top.sv
dv/colmix_tb.sv

/* Makefile */
SIM      = verilator
TOP      = colmix_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG      = sim.log
PASS_MSG = \*\*\* TEST PASSED \*\*\*

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# the log decides pass or fail, the simulator status is not trusted through tee
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
